// File: verilog/i2c_bus_pkg.sv
package i2c_bus_pkg;

    // fixed upper nibble of the control byte
    localparam logic [3:0] device_code = 4'b1010;

    // control byte bit 0 value that selects a read
    localparam logic rw_read = 1'b1;

    // eight data bits plus the acknowledge slot
    localparam int bit_slots = 9;

    // single-cycle bus events plus the synchronized data level
    typedef struct packed {
        logic start;      // data falls while scl high
        logic stop;       // data rises while scl high
        logic scl_rise;
        logic scl_fall;
        logic data;       // synchronized data line level
    } bus_event_t;

endpackage

// File: verilog/eeprom_mem_pkg.sv
package eeprom_mem_pkg;

    // 3 block bits plus the 8-bit word address
    localparam int addr_width = 11;

    localparam int mem_depth = 2048;

    typedef logic [addr_width-1:0] mem_addr_t;

    // one access per cycle, read is implied when we is low
    typedef struct packed {
        logic       we;
        mem_addr_t  addr;
        logic [7:0] wdata;
    } mem_req_t;

endpackage

// File: verilog/bus_sampler.sv
`timescale 1ns/100ps

module bus_sampler
(
    input  logic                    sda,
    input  logic                    reset,
    input  logic                    scl,
    input  logic                    data_in,
    output i2c_bus_pkg::bus_event_t ev
);

    logic [1:0] scl_sync;
    logic [1:0] data_sync;
    logic       scl_prev;
    logic       data_prev;

    // two-flop synchronizers, idle bus reads high
    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            scl_sync  <= 2'b11;
            data_sync <= 2'b11;
            scl_prev  <= 1'b1;
            data_prev <= 1'b1;
        end
        else
        begin
            scl_sync  <= {scl_sync[0], scl};
            data_sync <= {data_sync[0], data_in};
            scl_prev  <= scl_sync[1];
            data_prev <= data_sync[1];
        end
    end

    // registered events, third cycle after the line change
    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            ev <= '0;
        end
        else
        begin
            ev.start    <= scl_sync[1] & scl_prev & data_prev & ~data_sync[1];
            ev.stop     <= scl_sync[1] & scl_prev & ~data_prev & data_sync[1];
            ev.scl_rise <= scl_sync[1] & ~scl_prev;
            ev.scl_fall <= ~scl_sync[1] & scl_prev;
            ev.data     <= data_sync[1];
        end
    end

endmodule

// File: verilog/bit_counter.sv
`timescale 1ns/100ps

module bit_counter
(
    input  logic                    sda,
    input  logic                    reset,
    input  i2c_bus_pkg::bus_event_t ev,
    output logic                    last_bit,
    output logic                    ack_slot
);

    logic [3:0] count;   // slot index 0..8 within the current byte

    always_ff @(posedge sda)
    begin
        if (reset || ev.start)
        begin
            count <= '0;
        end
        else if (ev.scl_rise)
        begin
            if (count == 4'(i2c_bus_pkg::bit_slots - 1))
                count <= '0;
            else
                count <= count + 1'b1;
        end
    end

    // 8th data bit is on the line until its rising edge
    assign last_bit = (count == 4'(i2c_bus_pkg::bit_slots - 2));

    // set from the 8th rise until the 9th rise
    assign ack_slot = (count == 4'(i2c_bus_pkg::bit_slots - 1));

endmodule

// File: verilog/byte_shifter.sv
`timescale 1ns/100ps

module byte_shifter
(
    input  logic                    sda,
    input  logic                    reset,
    input  i2c_bus_pkg::bus_event_t ev,
    input  logic                    load,
    input  logic [7:0]              tx_byte,
    output logic [7:0]              rx_byte,
    output logic                    tx_bit
);

    logic [7:0] rx_reg;
    logic [8:0] tx_reg;

    // msb first, taken on each scl rise
    always_ff @(posedge sda)
    begin
        if (ev.scl_rise)
            rx_reg <= {rx_reg[6:0], ev.data};
    end

    // Load always lands between the 8th rise and the fall into the
    // acknowledge slot. The pad bit on top is dropped by that fall, so the
    // acknowledge slot never consumes a data bit.
    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            tx_reg <= '1;   // released line
        end
        else if (load)
        begin
            tx_reg <= {1'b1, tx_byte};
        end
        else if (ev.scl_fall)
        begin
            tx_reg <= {tx_reg[7:0], 1'b1};
        end
    end

    assign rx_byte = rx_reg;
    assign tx_bit  = tx_reg[8];

endmodule

// File: verilog/eeprom_fsm.sv
`timescale 1ns/100ps

module eeprom_fsm
(
    input  logic                     sda,
    input  logic                     reset,
    input  i2c_bus_pkg::bus_event_t  ev,
    input  logic                     last_bit,
    input  logic                     ack_slot,
    input  logic [7:0]               rx_byte,
    input  logic                     tx_bit,
    input  logic [7:0]               rdata,
    output logic                     load,
    output logic [7:0]               tx_byte,
    output eeprom_mem_pkg::mem_req_t req,
    output logic                     data_oe
);

    typedef enum logic [2:0] {
        st_idle,
        st_control,
        st_address,
        st_write,
        st_read,
        st_read_ack
    } state_t;

    state_t                                  state;
    eeprom_mem_pkg::mem_addr_t               ptr;
    logic [eeprom_mem_pkg::addr_width-9:0]   block;
    logic                                    byte_done;   // rx_byte valid this cycle
    logic                                    ack_pend;    // slave acks the current byte
    logic                                    fetch;
    logic                                    we;
    logic                                    ctrl_match;

    assign ctrl_match = (rx_byte[7:4] == i2c_bus_pkg::device_code);

    always_ff @(posedge sda)
    begin
        if (reset || ev.start)
            byte_done <= 1'b0;
        else
            byte_done <= ev.scl_rise & last_bit;
    end

    always_ff @(posedge sda)
    begin
        if (reset)
        begin
            state    <= st_idle;
            ptr      <= '0;
            block    <= '0;
            ack_pend <= 1'b0;
            fetch    <= 1'b0;
            we       <= 1'b0;
            load     <= 1'b0;
        end
        else
        begin
            fetch <= 1'b0;
            we    <= 1'b0;
            load  <= fetch;                   // rdata is valid one cycle after fetch
            if (we)
                ptr <= ptr + 1'b1;
            if (ev.start || ev.stop)
            begin
                state    <= ev.start ? st_control : st_idle;
                ack_pend <= 1'b0;
            end
            else if (byte_done)
            begin
                case (state)
                    st_control:
                    begin
                        ack_pend <= ctrl_match;
                        if (!ctrl_match)
                        begin
                            state <= st_idle;     // foreign device, line stays released
                        end
                        else
                        begin
                            block <= rx_byte[3:1];
                            if (rx_byte[0] == i2c_bus_pkg::rw_read)
                            begin
                                state <= st_read;
                                fetch <= 1'b1;    // current pointer
                            end
                            else
                            begin
                                state <= st_address;
                            end
                        end
                    end
                    st_address:
                    begin
                        ptr      <= {block, rx_byte};
                        ack_pend <= 1'b1;
                        state    <= st_write;
                    end
                    st_write:
                    begin
                        ack_pend <= 1'b1;
                        we       <= 1'b1;
                    end
                    st_read:
                    begin
                        ack_pend <= 1'b0;         // master owns this ack slot
                        ptr      <= ptr + 1'b1;
                        fetch    <= 1'b1;
                        state    <= st_read_ack;
                    end
                    default:
                    begin
                        ack_pend <= 1'b0;
                    end
                endcase
            end
            else if (state == st_read_ack && ev.scl_rise && ack_slot)
            begin
                state <= ev.data ? st_idle : st_read;   // nack ends the burst
            end
        end
    end

    // line updates one cycle after the scl fall event
    always_ff @(posedge sda)
    begin
        if (reset || ev.start || ev.stop)
        begin
            data_oe <= 1'b0;
        end
        else if (ev.scl_fall)
        begin
            if (ack_slot)
                data_oe <= ack_pend;
            else if (state == st_read)
                data_oe <= ~tx_bit;
            else
                data_oe <= 1'b0;
        end
    end

    always_comb
    begin
        req.we    = we;
        req.addr  = ptr;
        req.wdata = rx_byte;
    end

    assign tx_byte = rdata;

endmodule

// File: verilog/eeprom_array.sv
`timescale 1ns/100ps

module eeprom_array
(
    input  logic                     sda,
    input  eeprom_mem_pkg::mem_req_t req,
    output logic [7:0]               rdata
);

    logic [7:0] mem [eeprom_mem_pkg::mem_depth];

    always_ff @(posedge sda)
    begin
        if (req.we)
            mem[req.addr] <= req.wdata;
    end

    // registered read, one cycle latency
    always_ff @(posedge sda)
    begin
        rdata <= mem[req.addr];
    end

endmodule

// File: verilog/eeprom_top.sv
`timescale 1ns/100ps

module eeprom_top
(
    input  logic sda,
    input  logic reset,
    input  logic scl,
    input  logic data_in,
    output logic data_oe
);

    i2c_bus_pkg::bus_event_t  ev;
    eeprom_mem_pkg::mem_req_t req;
    logic                     last_bit;
    logic                     ack_slot;
    logic                     load;
    logic                     tx_bit;
    logic [7:0]               rx_byte;
    logic [7:0]               tx_byte;
    logic [7:0]               rdata;

    bus_sampler bus_sampler_inst (
        .sda     (sda),
        .reset   (reset),
        .scl     (scl),
        .data_in (data_in),
        .ev      (ev)
    );

    bit_counter bit_counter_inst (
        .sda      (sda),
        .reset    (reset),
        .ev       (ev),
        .last_bit (last_bit),
        .ack_slot (ack_slot)
    );

    byte_shifter byte_shifter_inst (
        .sda     (sda),
        .reset   (reset),
        .ev      (ev),
        .load    (load),
        .tx_byte (tx_byte),
        .rx_byte (rx_byte),
        .tx_bit  (tx_bit)
    );

    eeprom_fsm eeprom_fsm_inst (
        .sda      (sda),
        .reset    (reset),
        .ev       (ev),
        .last_bit (last_bit),
        .ack_slot (ack_slot),
        .rx_byte  (rx_byte),
        .tx_bit   (tx_bit),
        .rdata    (rdata),
        .load     (load),
        .tx_byte  (tx_byte),
        .req      (req),
        .data_oe  (data_oe)
    );

    eeprom_array eeprom_array_inst (
        .sda   (sda),
        .req   (req),
        .rdata (rdata)
    );

endmodule

// File: tb/eeprom_clock_gen.sv
`timescale 1ns/100ps

module eeprom_clock_gen
(
    output logic sda,
    output logic reset
);

    initial
    begin
        sda   = 1'b0;
        reset = 1'b1;
        repeat (4) @(posedge sda);
        #2 reset = 1'b0;
    end

    always #10 sda = ~sda;   // 20 ns period

endmodule

// File: tb/eeprom_assertions.sv
`timescale 1ns/100ps

module eeprom_assertions
(
    input logic                     sda,
    input logic                     reset,
    input i2c_bus_pkg::bus_event_t  ev,
    input eeprom_mem_pkg::mem_req_t req,
    input logic                     data_oe
);

    logic scl_hi;           // scl level rebuilt from the edge events
    int   fail_count = 0;

    always_ff @(posedge sda)
    begin
        if (reset || ev.scl_rise)
            scl_hi <= 1'b1;
        else if (ev.scl_fall)
            scl_hi <= 1'b0;
    end

    oe_scl_low: assert property (@(posedge sda) disable iff (reset)
        $changed(data_oe) |-> !scl_hi)
    else
    begin
        $error("data_oe changed while scl was high");
        fail_count++;
    end

    we_single: assert property (@(posedge sda) disable iff (reset) req.we |=> !req.we)
    else
    begin
        $error("write strobe high for two cycles");
        fail_count++;
    end

    oe_after_reset: assert property (@(posedge sda) reset |=> !data_oe)
    else
    begin
        $error("data_oe not low after reset");
        fail_count++;
    end

endmodule

bind eeprom_fsm eeprom_assertions eeprom_assertions_inst
    (.sda(sda), .reset(reset), .ev(ev), .req(req), .data_oe(data_oe));

// File: tb/eeprom_tb.sv
`timescale 1ns/100ps

module eeprom_tb;

    logic        sda;
    logic        reset;
    logic        scl;
    logic        data_m;     // master side of the data line
    logic        data_oe;
    logic        line;
    logic [31:0] lfsr;
    logic [7:0]  ref_mem [eeprom_mem_pkg::mem_depth];
    logic        ref_valid [eeprom_mem_pkg::mem_depth];
    eeprom_mem_pkg::mem_addr_t ptr;   // slave address pointer as the model sees it
    int          tests = 0;
    int          failed = 0;
    int          errors = 0;
    int          test_errors = 0;

    // open-drain line with pull-up where the slave can only pull low
    assign line = data_m & ~data_oe;

    eeprom_clock_gen clock_gen_inst (.sda(sda), .reset(reset));

    eeprom_top eeprom_top_inst (
        .sda     (sda),
        .reset   (reset),
        .scl     (scl),
        .data_in (line),
        .data_oe (data_oe)
    );

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act)
        begin
            $display("** Error %s: expected %h, actual %h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sda);
        #2;                                  // drive just after the edge
    endtask

    task automatic tick_with_timeout(inout int n, input int limit, input string what);
        if (n >= limit)
        begin
            $display("timeout while waiting for %s", what);
            $display("Some tests failed");
            $finish;
        end
        else
        begin
            wait_cycles(1);
            n++;
        end
    endtask

    // one scl pulse of 10 cycles low and 10 high with the line sampled mid high
    task automatic clock_bit(input logic b, output logic s);
        data_m = b;
        wait_cycles(5);
        scl = 1'b1;
        wait_cycles(5);
        s = line;
        wait_cycles(5);
        scl = 1'b0;
        wait_cycles(5);
    endtask

    task automatic send_byte(input logic [7:0] b, output logic ack);
        logic s;
        for (int i = 7; i >= 0; i--)
            clock_bit(b[i], s);
        clock_bit(1'b1, s);
        ack = ~s;
    endtask

    task automatic recv_byte(input logic master_ack, output logic [7:0] b);
        logic s;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, s);
            b[i] = s;
        end
        clock_bit(~master_ack, s);
    endtask

    task automatic bus_start();
        int n;
        n = 0;
        while (data_oe !== 1'b0)
            tick_with_timeout(n, 40, "slave to release the data line");
        data_m = 1'b1;
        wait_cycles(5);
        scl = 1'b1;
        wait_cycles(10);
        data_m = 1'b0;                       // falls while scl high
        wait_cycles(10);
        scl = 1'b0;
        wait_cycles(5);
    endtask

    task automatic bus_stop();
        data_m = 1'b0;
        wait_cycles(5);
        scl = 1'b1;
        wait_cycles(10);
        data_m = 1'b1;                       // rises while scl high
        wait_cycles(10);
    endtask

    task automatic write_burst(input eeprom_mem_pkg::mem_addr_t addr, input int len);
        logic       ack;
        logic [7:0] d;
        bus_start();
        send_byte({i2c_bus_pkg::device_code, addr[10:8], ~i2c_bus_pkg::rw_read}, ack);
        compare_value("ack_control", 1, ack);
        send_byte(addr[7:0], ack);
        compare_value("ack_address", 1, ack);
        ptr = addr;
        for (int i = 0; i < len; i++)
        begin
            d = 8'(rand_bits(8));
            send_byte(d, ack);
            compare_value("ack_data", 1, ack);
            ref_mem[ptr]   = d;
            ref_valid[ptr] = 1'b1;
            ptr++;                           // wraps over the whole 2048 bytes
        end
        bus_stop();
    endtask

    // reads len bytes from the model pointer and nacks the last one
    task automatic current_read(input int len);
        logic       ack;
        logic [7:0] d;
        bus_start();
        send_byte({i2c_bus_pkg::device_code, ptr[10:8], i2c_bus_pkg::rw_read}, ack);
        compare_value("ack_control", 1, ack);
        for (int i = 0; i < len; i++)
        begin
            recv_byte(i < len - 1, d);
            if (ref_valid[ptr])
                compare_value("read_data", ref_mem[ptr], d);
            else
            begin
                $display("read from an address that was never written: %h", ptr);
                test_errors++;
            end
            ptr++;
        end
        bus_stop();
    endtask

    // dummy write of the address and then a repeated start into the read
    task automatic random_read(input eeprom_mem_pkg::mem_addr_t addr, input int len);
        logic ack;
        bus_start();
        send_byte({i2c_bus_pkg::device_code, addr[10:8], ~i2c_bus_pkg::rw_read}, ack);
        compare_value("ack_control", 1, ack);
        send_byte(addr[7:0], ack);
        compare_value("ack_address", 1, ack);
        ptr = addr;
        current_read(len);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (test_errors != 0)
            failed++;
        $display("test %0d %s: %s", tests, name, (test_errors == 0) ? "ok" : "FAILED");
        errors += test_errors;
        test_errors = 0;
    endtask

    initial
    begin
        eeprom_mem_pkg::mem_addr_t addrs[$];
        eeprom_mem_pkg::mem_addr_t a;
        logic [7:0] pre;
        logic       ack;
        int         len;
        int         n;
        int         assert_fails;
        scl    = 1'b1;
        data_m = 1'b1;
        lfsr   = 32'hfab6cd74;
        for (int i = 0; i < eeprom_mem_pkg::mem_depth; i++)
            ref_valid[i] = 1'b0;
        n = 0;
        while (reset !== 1'b0)
            tick_with_timeout(n, 20, "reset release");
        wait_cycles(4);

        for (int i = 0; i < 6; i++)
        begin
            a = 11'(rand_bits(11));
            addrs.push_back(a);
            write_burst(a, 1);
        end
        foreach (addrs[i])
            random_read(addrs[i], 1);
        end_test("random byte write and read");

        a   = 11'(rand_bits(11));
        len = 2 + int'(rand_bits(3) % 7);
        write_burst(a, len);
        random_read(a, len);
        end_test("burst write and sequential read");

        random_read(a, 1);
        current_read(1);                     // pointer left at a + 1
        end_test("current address read");

        pre = 8'(rand_bits(8));
        if (pre[7:4] == i2c_bus_pkg::device_code)
            pre[7:4] = ~pre[7:4];
        bus_start();
        send_byte(pre, ack);
        compare_value("ack_foreign", 0, ack);
        bus_stop();
        random_read(addrs[0], 1);
        end_test("foreign device code");

        a = addrs[1];
        bus_start();
        send_byte({i2c_bus_pkg::device_code, a[10:8], ~i2c_bus_pkg::rw_read}, ack);
        compare_value("ack_control", 1, ack);
        for (int i = 7; i > 3; i--)
            clock_bit(a[i], ack);
        bus_stop();                          // aborts inside the address byte
        random_read(a, 1);
        end_test("stop inside address byte");

        assert_fails = eeprom_top_inst.eeprom_fsm_inst.eeprom_assertions_inst.fail_count;
        $display("tests %0d, failed %0d, check errors %0d, assertion failures %0d",
                 tests, failed, errors, assert_fails);
        if (failed == 0 && assert_fails == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: compile.f
verilog/i2c_bus_pkg.sv
verilog/eeprom_mem_pkg.sv
verilog/bus_sampler.sv
verilog/bit_counter.sv
verilog/byte_shifter.sv
verilog/eeprom_fsm.sv
verilog/eeprom_array.sv
verilog/eeprom_top.sv
tb/eeprom_clock_gen.sv
tb/eeprom_assertions.sv
tb/eeprom_tb.sv

// File: Bender.yml
package:
  name: eeprom_i2c

sources:
  - target: rtl
    files:
      - verilog/i2c_bus_pkg.sv
      - verilog/eeprom_mem_pkg.sv
      - verilog/bus_sampler.sv
      - verilog/bit_counter.sv
      - verilog/byte_shifter.sv
      - verilog/eeprom_fsm.sv
      - verilog/eeprom_array.sv
      - verilog/eeprom_top.sv
  - target: test
    files:
      - tb/eeprom_clock_gen.sv
      - tb/eeprom_assertions.sv
      - tb/eeprom_tb.sv
